// ==== branchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
    input  decodePkg::ctrl_t ctrl,
    input  wire              valid,
    input  isaPkg::word_t    opA,
    input  isaPkg::word_t    opB,
    input  isaPkg::word_t    nextPc,
    input  isaPkg::word_t    signImm,
    input  isaPkg::instIdx_t jumpIdx,
    output logic             pcSrc,
    output isaPkg::word_t    pcBranch
);

    import isaPkg::*;
    import decodePkg::*;

    logic  isEq;
    logic  isZero;
    logic  isNeg;
    logic  condMet;
    logic  taken;
    word_t idxTarget;
    word_t relTarget;

    assign isEq   = (opA == opB);
    assign isZero = (opA == '0);
    assign isNeg  = opA[WORD_W-1];

    always_comb begin
        case (ctrl.brCond)
            BR_EQ:   condMet = isEq;
            BR_NE:   condMet = !isEq;
            BR_GEZ:  condMet = !isNeg;
            BR_GTZ:  condMet = !isNeg && !isZero;
            BR_LEZ:  condMet = isNeg || isZero;
            BR_LTZ:  condMet = isNeg;
            default: condMet = 1'b0;
        endcase
    end

    assign taken = ctrl.brDirect || condMet;

    // region of the delay slot, not of the branch
    assign idxTarget = {nextPc[WORD_W-1:WORD_W-4], jumpIdx, 2'b00};
    assign relTarget = nextPc + {signImm[WORD_W-3:0], 2'b00};

    assign pcBranch = ctrl.brReg   ? opA       :
                      ctrl.jumpIdx ? idxTarget : relTarget;

    assign pcSrc = valid && ctrl.isBranch && taken;

endmodule

`default_nettype wire

// ==== decodePkg.sv ====
`default_nettype none

package decodePkg;

    typedef logic [4:0] aluOp_t;
    typedef logic [2:0] brCond_t;
    typedef logic [1:0] fwdSel_t;
    typedef logic [1:0] hiLoSel_t; // bit 1 hi, bit 0 lo

    localparam aluOp_t ALU_ADDU = 5'd0;
    localparam aluOp_t ALU_LUI  = 5'd1;
    localparam aluOp_t ALU_SUBU = 5'd2;
    localparam aluOp_t ALU_SLT  = 5'd3;
    localparam aluOp_t ALU_SLTU = 5'd4;
    localparam aluOp_t ALU_AND  = 5'd5;
    localparam aluOp_t ALU_OR   = 5'd6;
    localparam aluOp_t ALU_XOR  = 5'd7;
    localparam aluOp_t ALU_NOR  = 5'd8;
    localparam aluOp_t ALU_SLL  = 5'd9;
    localparam aluOp_t ALU_SRL  = 5'd10;
    localparam aluOp_t ALU_SRA  = 5'd11;
    localparam aluOp_t ALU_ADD  = 5'd12; // trapping add, overflow handled downstream
    localparam aluOp_t ALU_SUB  = 5'd13;

    localparam brCond_t BR_NONE = 3'd0;
    localparam brCond_t BR_EQ   = 3'd1;
    localparam brCond_t BR_NE   = 3'd2;
    localparam brCond_t BR_GEZ  = 3'd3;
    localparam brCond_t BR_GTZ  = 3'd4;
    localparam brCond_t BR_LEZ  = 3'd5;
    localparam brCond_t BR_LTZ  = 3'd6;

    localparam fwdSel_t FWD_RF = 2'd0;
    localparam fwdSel_t FWD_ME = 2'd1;
    localparam fwdSel_t FWD_WB = 2'd2;

    localparam hiLoSel_t HL_LO   = 2'b01;
    localparam hiLoSel_t HL_HI   = 2'b10;
    localparam hiLoSel_t HL_BOTH = 2'b11;

    typedef struct packed {
        isaPkg::word_t pc;
        isaPkg::word_t nextPc;
        isaPkg::word_t ins;
    } ifBus_t;

    typedef struct packed {
        logic             valid;
        logic             regWrite;
        isaPkg::regAddr_t writeReg;
        isaPkg::word_t    finalData;
        logic             hiLoWrite;
        hiLoSel_t         hiLoSel;
        isaPkg::word_t    hiVal;
        isaPkg::word_t    loVal;
    } wbBus_t;

    typedef struct packed {
        aluOp_t   aluOp;
        logic     regWrite;
        logic     memWrite;
        logic     memToReg;
        logic     regDst;       // rd instead of rt
        logic     aluSrc1;      // rs, cleared means shamt
        logic     aluSrc2;      // rt, cleared means immediate
        logic     writeReg31;
        logic     writePcPlus8;
        logic     isBranch;
        brCond_t  brCond;
        logic     brDirect;     // taken without a condition
        logic     brReg;        // target from rs
        logic     jumpIdx;      // target from the 26 bit index
        logic     mul;
        logic     mulSigned;
        logic     div;
        logic     divSigned;
        logic     hiLoWrite;
        logic     hiLoRead;
        hiLoSel_t hiLoSel;
        logic     zeroExtImm;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== gprFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module gprFile (
    input  wire               clk,
    input  isaPkg::regAddr_t  raddr1,
    input  isaPkg::regAddr_t  raddr2,
    output isaPkg::word_t     rdata1,
    output isaPkg::word_t     rdata2,
    input  decodePkg::wbBus_t wb
);

    import isaPkg::*;

    localparam int NUM_REGS = 32;

    word_t regs [NUM_REGS];
    logic  wen;

    assign wen = wb.valid && wb.regWrite;

    always_ff @(posedge clk) begin
        if (wen) begin
            regs[wb.writeReg] <= wb.finalData;
        end
    end

    // $0 is hardwired, whatever was written there
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== hiLoRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module hiLoRegs (
    input  wire                 clk,
    input  decodePkg::wbBus_t   wb,
    input  decodePkg::hiLoSel_t readSel,
    output isaPkg::word_t       readData
);

    import isaPkg::*;

    localparam int HI_BIT = 1;
    localparam int LO_BIT = 0;

    word_t hiReg;
    word_t loReg;
    word_t hiRead;
    word_t loRead;
    logic  hiWrite;
    logic  loWrite;

    assign hiWrite = wb.valid && wb.hiLoWrite && wb.hiLoSel[HI_BIT];
    assign loWrite = wb.valid && wb.hiLoWrite && wb.hiLoSel[LO_BIT];

    always_ff @(posedge clk) begin
        if (hiWrite) begin
            hiReg <= wb.hiVal;
        end
        if (loWrite) begin
            loReg <= wb.loVal;
        end
    end

    // same cycle bypass from writeback
    assign hiRead = hiWrite ? wb.hiVal : hiReg;
    assign loRead = loWrite ? wb.loVal : loReg;

    assign readData = readSel[HI_BIT] ? hiRead :
                      readSel[LO_BIT] ? loRead : '0;

endmodule

`default_nettype wire

// ==== idStage.f ====
isaPkg.sv
decodePkg.sv
gprFile.sv
hiLoRegs.sv
instDecoder.sv
branchUnit.sv
idStage.sv
idStageTb.sv

// ==== idStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module idStage (
    input  wire                clk,
    input  wire                resetn,
    input  decodePkg::ifBus_t  ifBus,
    input  wire                ifValid,
    input  wire                stall,
    input  wire                exAllowin,
    input  isaPkg::word_t      meData,
    input  decodePkg::wbBus_t  wb,
    input  decodePkg::fwdSel_t fwdA,
    input  decodePkg::fwdSel_t fwdB,
    output logic               idValid,
    output logic               idAllowin,
    output logic               idToExValid,
    output isaPkg::word_t      idPc,
    output isaPkg::word_t      idNextPc,
    output isaPkg::regAddr_t   rs,
    output isaPkg::regAddr_t   rt,
    output isaPkg::regAddr_t   rd,
    output isaPkg::word_t      extImm,
    output isaPkg::word_t      shamtImm,
    output decodePkg::ctrl_t   ctrl,
    output isaPkg::word_t      rdata1,
    output isaPkg::word_t      rdata2,
    output isaPkg::word_t      hiLoData,
    output logic               pcSrc,
    output isaPkg::word_t      pcBranch
);

    import isaPkg::*;
    import decodePkg::*;

    ifBus_t   held;     // stage register payload
    logic     readyGo;
    word_t    rfData1;
    word_t    rfData2;
    word_t    signImm;
    instIdx_t insIdx;

    function automatic word_t fwdMux(input fwdSel_t sel, input word_t rfVal,
                                     input word_t meVal, input word_t wbVal);
        if (sel == FWD_ME) begin
            return meVal;
        end else if (sel == FWD_WB) begin
            return wbVal;
        end
        return rfVal;
    endfunction

    assign readyGo     = !stall;
    assign idAllowin   = !idValid || (readyGo && exAllowin);
    assign idToExValid = idValid && readyGo;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            idValid <= 1'b0;
        end else if (idAllowin) begin
            idValid <= ifValid;
        end
    end

    always_ff @(posedge clk) begin
        if (ifValid && idAllowin) begin
            held <= ifBus;
        end
    end

    assign idPc     = held.pc;
    assign idNextPc = held.nextPc;
    assign rs       = held.ins[25:21];
    assign rt       = held.ins[20:16];
    assign rd       = held.ins[15:11];
    assign insIdx   = held.ins[25:0];

    instDecoder decoder_i (
        .ins      (held.ins),
        .ctrl     (ctrl),
        .signImm  (signImm),
        .extImm   (extImm),
        .shamtImm (shamtImm)
    );

    gprFile gpr_i (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rfData1),
        .rdata2 (rfData2),
        .wb     (wb)
    );

    // memory stage wins over writeback
    assign rdata1 = fwdMux(fwdA, rfData1, meData, wb.finalData);
    assign rdata2 = fwdMux(fwdB, rfData2, meData, wb.finalData);

    hiLoRegs hiLo_i (
        .clk      (clk),
        .wb       (wb),
        .readSel  (ctrl.hiLoSel),
        .readData (hiLoData)
    );

    branchUnit branch_i (
        .ctrl     (ctrl),
        .valid    (idValid),
        .opA      (rdata1),
        .opB      (rdata2),
        .nextPc   (held.nextPc),
        .signImm  (signImm),
        .jumpIdx  (insIdx),
        .pcSrc    (pcSrc),
        .pcBranch (pcBranch)
    );

endmodule

`default_nettype wire

// ==== idStagePatterns.txt ====
// kind 1 gpr write: reg data | kind 2 hi/lo write: sel hi lo keep | kind 5 idle check | 0 ends
// kind 3 issue: ins pc fwd(A,B) me wbData ctrl extImm shamt rdata1 rdata2 hiLo pcSrc pcBranch
// pcSrc 0 no branch, 1 taken, 2 not taken with target; kind 4 hold: mode ins pc ctrl ins2 pc2
1 0 DEADBEEF
1 1 80000004
1 2 00000005
1 3 00000005
1 4 00000000
1 5 12345678
2 3 11112222 33334444 0
3 00A23021 00001000 00 0 0 009C0000 00003021 0 12345678 5 0 0 0
3 00233822 00001004 10 CAFEF00D 0 0D9C0000 00003822 0 CAFEF00D 5 0 0 0
3 00854027 00001008 02 0 0BADF00D 089C0000 00004027 0 0 0BADF00D 0 0 0
3 000249C0 0000100C 00 0 0 09940000 000049C0 7 0 5 0 0 0
3 00255007 00001010 00 0 0 0B9C0000 00005007 0 80000004 12345678 0 0 0
3 2043FFFC 00001014 00 0 0 0C880000 FFFFFFFC 1F 5 5 0 0 0
3 30A48001 00001018 00 0 0 05880001 00008001 0 12345678 0 0 0 0
3 3401FFC0 0000101C 00 0 0 06880001 0000FFC0 1F 0 80000004 0 0 0
3 38620040 00001020 00 0 0 07880001 00000040 1 5 5 0 0 0
3 3C059000 00001024 00 0 0 01880000 FFFF9000 0 0 12345678 0 0 0
3 28227FFF 00001028 00 0 0 03880000 00007FFF 1F 80000004 5 0 0 0
3 8CA3FFF8 0000102C 00 0 0 00A80000 FFFFFFF8 1F 12345678 5 0 0 0
3 AC410010 00001030 00 0 0 00480000 00000010 0 5 80000004 0 0 0
3 00220018 00001034 00 0 0 001C0196 00000018 0 80000004 5 11112222 0 0
3 00A3001B 00001038 00 0 0 001C0056 0000001B 0 12345678 5 11112222 0 0
3 00003010 0000103C 00 0 0 009C000C 00003010 0 0 0 11112222 0 0
3 00003812 00001040 00 0 0 009C000A 00003812 0 0 0 33334444 0 0
2 2 5555AAAA 0 1
3 00003010 00001044 00 0 0 009C000C 00003010 0 0 0 5555AAAA 0 0
3 00A00011 00001048 00 0 0 001C0014 00000011 0 12345678 0 5555AAAA 0 0
3 10430004 00400100 00 0 0 00089000 00000004 0 5 5 0 1 00400114
3 1443FFFE 00400200 00 0 0 0008A000 FFFFFFFE 1F 5 5 0 2 004001FC
3 18200008 00400300 00 0 0 0008D000 00000008 0 80000004 0 0 1 00400324
3 1C800001 00400400 00 0 0 0008C000 00000001 0 0 0 0 2 00400408
3 04200010 00400500 00 0 0 0008E000 00000010 0 80000004 0 0 1 00400544
3 04410010 00400600 00 0 0 0008B000 00000010 0 5 80000004 0 1 00400644
3 04310010 00400700 01 0000ABCD 0 008BB000 00000010 0 80000004 0000ABCD 0 2 00400744
3 04300010 00400800 01 00000001 0 008BE000 00000010 0 80000004 1 0 1 00400844
3 08030040 BFC00FFC 00 0 0 00088A00 00000040 1 0 5 0 1 B00C0100
3 0C020008 1FFFFFFC 00 0 0 008B8A00 00000008 0 0 5 0 1 20080020
3 00A00008 00400900 00 0 0 001C8C00 00000008 0 12345678 0 0 1 12345678
3 0020F809 00400A00 20 0 00400A40 009D8C00 FFFFF809 0 00400A40 0 0 1 00400A40
5
4 1 00A23021 00002000 009C0000 00233822 00002004
4 2 00233822 00002100 0D9C0000 00854027 00002104
0

// ==== idStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module idStageTb;

    import isaPkg::*;
    import decodePkg::*;

    localparam int PAT_DEPTH  = 1024;
    localparam int WAIT_LIMIT = 20;
    localparam int DRIVE_DLY  = 10;
    localparam int SAMPLE_DLY = 40; // counted from the drive point

    logic     clk;
    logic     resetn;
    ifBus_t   ifBus;
    logic     ifValid;
    logic     stall;
    logic     exAllowin;
    word_t    meData;
    wbBus_t   wb;
    fwdSel_t  fwdA;
    fwdSel_t  fwdB;
    logic     idValid;
    logic     idAllowin;
    logic     idToExValid;
    word_t    idPc;
    word_t    idNextPc;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    word_t    extImm;
    word_t    shamtImm;
    ctrl_t    ctrl;
    word_t    rdata1;
    word_t    rdata2;
    word_t    hiLoData;
    logic     pcSrc;
    word_t    pcBranch;

    logic [31:0] pat [0:PAT_DEPTH-1];
    int          errorCount;
    logic        timedOut;
    logic        hlPending;  // hi/lo write held back until the next issue
    hiLoSel_t    pendSel;
    word_t       pendHi;
    word_t       pendLo;

    idStage idStage_i (
        .clk(clk), .resetn(resetn), .ifBus(ifBus), .ifValid(ifValid),
        .stall(stall), .exAllowin(exAllowin), .meData(meData), .wb(wb),
        .fwdA(fwdA), .fwdB(fwdB), .idValid(idValid), .idAllowin(idAllowin),
        .idToExValid(idToExValid), .idPc(idPc), .idNextPc(idNextPc),
        .rs(rs), .rt(rt), .rd(rd), .extImm(extImm), .shamtImm(shamtImm),
        .ctrl(ctrl), .rdata1(rdata1), .rdata2(rdata2), .hiLoData(hiLoData),
        .pcSrc(pcSrc), .pcBranch(pcBranch)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // five bit register number starting at bit lsb of an instruction word
    function automatic word_t regField(input word_t ins, input int lsb);
        return (ins >> lsb) & 32'h1f;
    endfunction

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errorCount++;
        end
    endtask

    task automatic waitAllowin();
        int n;
        n = 0;
        #5;
        while (idAllowin !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #(DRIVE_DLY);
            n++;
        end
        if (idAllowin !== 1'b1) begin
            $display("timeout: idAllowin never went high");
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    task automatic waitIdle();
        int n;
        n = 0;
        #5;
        while (idValid !== 1'b0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            #(DRIVE_DLY);
            n++;
        end
        if (idValid !== 1'b0) begin
            $display("timeout: idValid never dropped");
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    task automatic gprWrite(input int b);
        @(posedge clk);
        #(DRIVE_DLY);
        wb = '0;
        wb.valid = 1'b1;
        wb.regWrite = 1'b1;
        wb.writeReg = pat[b+1][4:0];
        wb.finalData = pat[b+2];
        @(posedge clk);
        #(DRIVE_DLY);
        wb = '0;
    endtask

    task automatic hiLoWrite(input int b);
        if (pat[b+4] != 0) begin
            hlPending = 1'b1; // goes out in the cycle after the next load
            pendSel = pat[b+1][1:0];
            pendHi = pat[b+2];
            pendLo = pat[b+3];
        end else begin
            @(posedge clk);
            #(DRIVE_DLY);
            wb = '0;
            wb.valid = 1'b1;
            wb.hiLoWrite = 1'b1;
            wb.hiLoSel = pat[b+1][1:0];
            wb.hiVal = pat[b+2];
            wb.loVal = pat[b+3];
            @(posedge clk);
            #(DRIVE_DLY);
            wb = '0;
        end
    endtask

    task automatic runIssue(input int b);
        word_t ins;
        word_t pc;
        word_t fwd;
        ins = pat[b+1];
        pc = pat[b+2];
        fwd = pat[b+3];
        @(posedge clk);
        #(DRIVE_DLY);
        ifBus.ins = ins;
        ifBus.pc = pc;
        ifBus.nextPc = pc + 32'd4;
        ifValid = 1'b1;
        fwdA = fwd[5:4];
        fwdB = fwd[1:0];
        meData = (fwdA == FWD_ME || fwdB == FWD_ME) ? pat[b+4] : $urandom;
        wb = '0;
        wb.finalData = pat[b+5];
        waitAllowin();
        if (timedOut) begin
            return;
        end
        @(posedge clk);
        #(DRIVE_DLY);
        ifValid = 1'b0;
        if (hlPending) begin
            wb.valid = 1'b1;
            wb.hiLoWrite = 1'b1;
            wb.hiLoSel = pendSel;
            wb.hiVal = pendHi;
            wb.loVal = pendLo;
            hlPending = 1'b0;
        end
        #(SAMPLE_DLY);
        checkBit("idValid", idValid, 1'b1);
        checkWord("idPc", idPc, pc);
        checkWord("idNextPc", idNextPc, pc + 32'd4);
        checkWord("rs", {27'b0, rs}, regField(ins, 21));
        checkWord("rt", {27'b0, rt}, regField(ins, 16));
        checkWord("rd", {27'b0, rd}, regField(ins, 11));
        checkWord("ctrl", {3'b0, ctrl}, pat[b+6]);
        checkWord("extImm", extImm, pat[b+7]);
        checkWord("shamtImm", shamtImm, pat[b+8]);
        checkWord("rdata1", rdata1, pat[b+9]);
        checkWord("rdata2", rdata2, pat[b+10]);
        checkWord("hiLoData", hiLoData, pat[b+11]);
        checkBit("pcSrc", pcSrc, pat[b+12] == 1);
        if (pat[b+12] != 0) begin
            checkWord("pcBranch", pcBranch, pat[b+13]);
        end
    endtask

    task automatic runIdle();
        @(posedge clk);
        #(DRIVE_DLY);
        ifValid = 1'b0;
        waitIdle();
        if (timedOut) begin
            return;
        end
        checkBit("pcSrc", pcSrc, 1'b0);
    endtask

    task automatic runHold(input int b);
        logic byStall;
        byStall = (pat[b+1] == 1);
        @(posedge clk);
        #(DRIVE_DLY);
        wb = '0;
        ifBus.ins = pat[b+2];
        ifBus.pc = pat[b+3];
        ifBus.nextPc = pat[b+3] + 32'd4;
        ifValid = 1'b1;
        waitAllowin();
        if (timedOut) begin
            return;
        end
        @(posedge clk);
        #(DRIVE_DLY);
        stall = byStall;
        exAllowin = byStall; // mode 2 holds through execute back-pressure
        ifBus.ins = pat[b+5];   // a different instruction is offered
        ifBus.pc = pat[b+6];
        ifBus.nextPc = pat[b+6] + 32'd4;
        repeat (3) begin
            #(SAMPLE_DLY);
            checkBit("idAllowin", idAllowin, 1'b0);
            checkBit("idToExValid", idToExValid, !byStall);
            checkBit("idValid", idValid, 1'b1);
            checkWord("idPc", idPc, pat[b+3]);
            checkWord("ctrl", {3'b0, ctrl}, pat[b+4]);
            @(posedge clk);
            #(DRIVE_DLY);
        end
        stall = 1'b0;
        exAllowin = 1'b1;
        waitAllowin();
        if (timedOut) begin
            return;
        end
        @(posedge clk);
        #(DRIVE_DLY);
        ifValid = 1'b0;
        #(SAMPLE_DLY);
        checkBit("idValid", idValid, 1'b1);
        checkWord("idPc", idPc, pat[b+6]);
    endtask

    initial begin
        int idx;
        int kind;
        int testNum;
        int errBefore;
        int passCount;
        int failCount;
        logic badKind;
        void'($urandom(32'h79c8));
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        badKind = 1'b0;
        timedOut = 1'b0;
        hlPending = 1'b0;
        pendSel = '0;
        pendHi = '0;
        pendLo = '0;
        resetn = 1'b0;
        ifBus = '0;
        ifValid = 1'b0;
        stall = 1'b0;
        exAllowin = 1'b1;
        meData = '0;
        wb = '0;
        fwdA = FWD_RF;
        fwdB = FWD_RF;
        for (int i = 0; i < PAT_DEPTH; i++) begin
            pat[i] = '0;
        end
        $readmemh("idStagePatterns.txt", pat);

        repeat (2) @(posedge clk);
        #(DRIVE_DLY);
        resetn = 1'b1;
        #(SAMPLE_DLY);
        checkBit("idValid", idValid, 1'b0);
        checkBit("idToExValid", idToExValid, 1'b0);
        checkBit("pcSrc", pcSrc, 1'b0);
        checkBit("idAllowin", idAllowin, 1'b1);
        if (errorCount == 0) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("test 0 reset: %s", (errorCount == 0) ? "ok" : "failed");

        idx = 0;
        testNum = 1;
        while (idx < PAT_DEPTH && pat[idx] != 0 && !badKind && !timedOut) begin
            kind = pat[idx];
            errBefore = errorCount;
            case (kind)
                1: begin gprWrite(idx); idx += 3; end
                2: begin hiLoWrite(idx); idx += 5; end
                3: begin runIssue(idx); idx += 14; end
                4: begin runHold(idx); idx += 7; end
                5: begin runIdle(); idx += 1; end
                default: begin
                    $display("pattern file holds an unknown record kind %0d", kind);
                    errorCount++;
                    badKind = 1'b1;
                end
            endcase
            if (errorCount == errBefore) begin
                passCount++;
            end else begin
                failCount++;
            end
            $display("test %0d kind %0d: %s", testNum, kind,
                     (errorCount == errBefore) ? "ok" : "failed");
            testNum++;
        end

        $display("tests done: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== instDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
    input  isaPkg::word_t    ins,
    output decodePkg::ctrl_t ctrl,
    output isaPkg::word_t    signImm,
    output isaPkg::word_t    extImm,
    output isaPkg::word_t    shamtImm
);

    import isaPkg::*;
    import decodePkg::*;

    opcode_t  op;
    funct_t   fn;
    regAddr_t rtField;
    logic     isSpecial;

    assign op        = ins[31:26];
    assign fn        = ins[5:0];
    assign rtField   = ins[20:16];
    assign isSpecial = (op == OP_SPECIAL);

    always_comb begin
        ctrl          = '0;
        ctrl.aluOp    = ALU_ADDU; // also the address add of lw/sw
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc1  = 1'b1;
        ctrl.regDst   = isSpecial;
        ctrl.aluSrc2  = isSpecial;
        ctrl.brCond   = BR_NONE;

        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_ADDU: ctrl.aluOp = ALU_ADDU;
                    FN_ADD:  ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUBU;
                    FN_SUB:  ctrl.aluOp = ALU_SUB;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_SLTU: ctrl.aluOp = ALU_SLTU;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_XOR:  ctrl.aluOp = ALU_XOR;
                    FN_NOR:  ctrl.aluOp = ALU_NOR;
                    FN_SLLV: ctrl.aluOp = ALU_SLL;
                    FN_SRLV: ctrl.aluOp = ALU_SRL;
                    FN_SRAV: ctrl.aluOp = ALU_SRA;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        // shift amount from the shamt field
                        ctrl.aluSrc1 = 1'b0;
                        ctrl.aluOp   = (fn == FN_SLL) ? ALU_SLL :
                                       (fn == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_JR, FN_JALR: begin
                        ctrl.isBranch     = 1'b1;
                        ctrl.brDirect     = 1'b1;
                        ctrl.brReg        = 1'b1;
                        ctrl.regWrite     = (fn == FN_JALR);
                        ctrl.writePcPlus8 = (fn == FN_JALR); // link goes to rd
                    end
                    FN_MULT, FN_MULTU: begin
                        ctrl.mul       = 1'b1;
                        ctrl.mulSigned = (fn == FN_MULT);
                        ctrl.hiLoWrite = 1'b1;
                        ctrl.hiLoSel   = HL_BOTH;
                        ctrl.regWrite  = 1'b0;
                    end
                    FN_DIV, FN_DIVU: begin
                        ctrl.div       = 1'b1;
                        ctrl.divSigned = (fn == FN_DIV);
                        ctrl.hiLoWrite = 1'b1;
                        ctrl.hiLoSel   = HL_BOTH;
                        ctrl.regWrite  = 1'b0;
                    end
                    FN_MFHI, FN_MFLO: begin
                        ctrl.hiLoRead = 1'b1;
                        ctrl.hiLoSel  = (fn == FN_MFHI) ? HL_HI : HL_LO;
                    end
                    FN_MTHI, FN_MTLO: begin
                        ctrl.hiLoWrite = 1'b1;
                        ctrl.hiLoSel   = (fn == FN_MTHI) ? HL_HI : HL_LO;
                        ctrl.regWrite  = 1'b0;
                    end
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                ctrl.isBranch     = 1'b1;
                ctrl.brCond       = rtField[0] ? BR_GEZ : BR_LTZ; // rt bit 0 picks gez
                ctrl.writeReg31   = (rtField == RT_BLTZAL) || (rtField == RT_BGEZAL);
                ctrl.writePcPlus8 = ctrl.writeReg31;
                ctrl.regWrite     = ctrl.writeReg31;
                if (rtField != RT_BLTZ && rtField != RT_BGEZ && !ctrl.writeReg31) begin
                    ctrl.isBranch = 1'b0;
                    ctrl.brCond   = BR_NONE;
                end
            end
            OP_J, OP_JAL: begin
                ctrl.isBranch     = 1'b1;
                ctrl.brDirect     = 1'b1;
                ctrl.jumpIdx      = 1'b1;
                ctrl.writeReg31   = (op == OP_JAL);
                ctrl.writePcPlus8 = (op == OP_JAL);
                ctrl.regWrite     = (op == OP_JAL);
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                ctrl.isBranch = 1'b1;
                ctrl.regWrite = 1'b0;
                ctrl.brCond   = (op == OP_BEQ)  ? BR_EQ  :
                                (op == OP_BNE)  ? BR_NE  :
                                (op == OP_BLEZ) ? BR_LEZ : BR_GTZ;
            end
            OP_ADDI:  ctrl.aluOp = ALU_ADD;
            OP_ADDIU: ctrl.aluOp = ALU_ADDU;
            OP_SLTI:  ctrl.aluOp = ALU_SLT;
            OP_SLTIU: ctrl.aluOp = ALU_SLTU;
            OP_LUI:   ctrl.aluOp = ALU_LUI;
            OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.zeroExtImm = 1'b1;
                ctrl.aluOp      = (op == OP_ANDI) ? ALU_AND :
                                  (op == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LW: ctrl.memToReg = 1'b1;
            OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.regWrite = 1'b0;
            end
            default: ;
        endcase
    end

    assign signImm  = {{16{ins[15]}}, ins[15:0]};
    assign extImm   = ctrl.zeroExtImm ? {16'b0, ins[15:0]} : signImm;
    assign shamtImm = {27'b0, ins[10:6]};

endmodule

`default_nettype wire

// ==== isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int INST_IDX_W = 26;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT_W-1:0]    funct_t;
    typedef logic [INST_IDX_W-1:0] instIdx_t;

    // primary opcodes, bits 31..26
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_SW      = 6'b101011;

    // SPECIAL function codes, bits 5..0
    localparam funct_t FN_SLL   = 6'b000000;
    localparam funct_t FN_SRL   = 6'b000010;
    localparam funct_t FN_SRA   = 6'b000011;
    localparam funct_t FN_SLLV  = 6'b000100;
    localparam funct_t FN_SRLV  = 6'b000110;
    localparam funct_t FN_SRAV  = 6'b000111;
    localparam funct_t FN_JR    = 6'b001000;
    localparam funct_t FN_JALR  = 6'b001001;
    localparam funct_t FN_MFHI  = 6'b010000;
    localparam funct_t FN_MTHI  = 6'b010001;
    localparam funct_t FN_MFLO  = 6'b010010;
    localparam funct_t FN_MTLO  = 6'b010011;
    localparam funct_t FN_MULT  = 6'b011000;
    localparam funct_t FN_MULTU = 6'b011001;
    localparam funct_t FN_DIV   = 6'b011010;
    localparam funct_t FN_DIVU  = 6'b011011;
    localparam funct_t FN_ADD   = 6'b100000;
    localparam funct_t FN_ADDU  = 6'b100001;
    localparam funct_t FN_SUB   = 6'b100010;
    localparam funct_t FN_SUBU  = 6'b100011;
    localparam funct_t FN_AND   = 6'b100100;
    localparam funct_t FN_OR    = 6'b100101;
    localparam funct_t FN_XOR   = 6'b100110;
    localparam funct_t FN_NOR   = 6'b100111;
    localparam funct_t FN_SLT   = 6'b101010;
    localparam funct_t FN_SLTU  = 6'b101011;

    // REGIMM codes live in the rt field
    localparam regAddr_t RT_BLTZ   = 5'b00000;
    localparam regAddr_t RT_BGEZ   = 5'b00001;
    localparam regAddr_t RT_BLTZAL = 5'b10000;
    localparam regAddr_t RT_BGEZAL = 5'b10001;

    localparam regAddr_t LINK_REG = 5'd31; // return address of jal and the *al branches

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module idStageTb -f idStage.f -o idStageTb \
    && ./obj_dir/idStageTb > sim.log 2>&1 \
    || echo "build or run returned an error"
cat sim.log 2>/dev/null
grep -qF '** PASS **' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
